//--- src/toaplan_pkg.sv
package toaplan_pkg;

	// ==============================
	// Game input words
	// ==============================

	// One player's controls, up in bit 0
	typedef struct packed {
		logic [3:0] fire;
		logic       right;
		logic       left;
		logic       down;
		logic       up;
	} player_t;

	// Coins and starts, coin1 in bit 0
	typedef struct packed {
		logic start2;
		logic start1;
		logic coin2;
		logic coin1;
	} sys_t;

	// External memory word, even byte in the low half
	typedef struct packed {
		logic [7:0] odd;
		logic [7:0] even;
	} rom_word_t;

	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_ROM,
		LOAD_SKIP
	} load_state_t;

	// ==============================
	// Joystick word bit positions
	// ==============================
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE0 = 4;
	localparam int JOY_COIN  = 8;
	localparam int JOY_START = 9;

endpackage

//--- src/rom_loader.sv
`timescale 1ns/1ps

module rom_loader #(
	parameter int ROM_INDEX   = 0,
	parameter int ADDR_OFFSET = 2,
	parameter int WORD_ADDR_W = 24
) (
	input  logic                   clk_72,
	input  logic                   reset,
	input  logic                   download,
	input  logic [7:0]             index,
	input  logic                   ioctl_wr,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	output logic                   rom_we,
	output logic [WORD_ADDR_W-1:0] rom_addr,
	output toaplan_pkg::rom_word_t rom_data,
	output logic                   rom_loaded,
	output logic                   busy
);
	import toaplan_pkg::*;

	load_state_t state;
	load_state_t state_next;
	logic [24:0] eff_addr;
	logic        addr_ok;
	logic        take;
	logic [7:0]  even_byte;

	// ==============================
	// Download session tracking
	// ==============================
	always_comb begin
		state_next = state;
		case (state)
			LOAD_IDLE: begin
				if (download) begin
					state_next = (index == 8'(ROM_INDEX)) ? LOAD_ROM : LOAD_SKIP;
				end
			end
			default: begin
				if (!download) begin
					state_next = LOAD_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk_72) begin
		if (reset) begin
			state <= LOAD_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Header bytes in front of the ROM image are skipped
	assign eff_addr = ioctl_addr - 25'(ADDR_OFFSET);
	assign addr_ok  = (ioctl_addr >= 25'(ADDR_OFFSET));
	assign take     = ioctl_wr && addr_ok && (state_next == LOAD_ROM) &&
		(index == 8'(ROM_INDEX));

	// ==============================
	// Byte pairing
	// ==============================
	always_ff @(posedge clk_72) begin
		if (take && !eff_addr[0]) begin
			even_byte <= ioctl_dout;
		end
		if (take && eff_addr[0]) begin
			rom_addr      <= eff_addr[WORD_ADDR_W:1];
			rom_data.odd  <= ioctl_dout;
			rom_data.even <= even_byte;
		end
	end

	always_ff @(posedge clk_72) begin
		if (reset) begin
			rom_we <= 1'b0;
		end else begin
			rom_we <= take && eff_addr[0];
		end
	end

	// End of download seen as high then low on consecutive edges
	always_ff @(posedge clk_72) begin
		if (reset) begin
			busy       <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			busy <= download;
			if (busy && !download) begin
				rom_loaded <= 1'b1;
			end
		end
	end

endmodule

//--- src/control_mapper.sv
`timescale 1ns/1ps

module control_mapper (
	input  logic                 clk_72,
	input  logic                 reset,
	input  logic [31:0]          joystick_0,
	input  logic [31:0]          joystick_1,
	input  logic                 joyswap,
	input  logic                 rotate,
	output toaplan_pkg::player_t p1,
	output toaplan_pkg::player_t p2,
	output toaplan_pkg::sys_t    sys
);
	import toaplan_pkg::*;

	logic [31:0] src_p1;
	logic [31:0] src_p2;
	player_t     p1_next;
	player_t     p2_next;
	sys_t        sys_next;

	// ==============================
	// Field extraction and rotation
	// ==============================
	function automatic player_t map_player(input logic [31:0] joy, input logic rot);
		player_t pl;
		pl.fire = joy[JOY_FIRE0 +: 4];
		if (rot) begin
			// Quarter turn for a cabinet mounted on its side
			pl.up    = joy[JOY_RIGHT];
			pl.right = joy[JOY_DOWN];
			pl.down  = joy[JOY_LEFT];
			pl.left  = joy[JOY_UP];
		end else begin
			pl.up    = joy[JOY_UP];
			pl.right = joy[JOY_RIGHT];
			pl.down  = joy[JOY_DOWN];
			pl.left  = joy[JOY_LEFT];
		end
		return pl;
	endfunction

	// Source word per player
	assign src_p1 = joyswap ? joystick_1 : joystick_0;
	assign src_p2 = joyswap ? joystick_0 : joystick_1;

	always_comb begin
		p1_next         = map_player(src_p1, rotate);
		p2_next         = map_player(src_p2, rotate);
		sys_next.coin1  = src_p1[JOY_COIN];
		sys_next.coin2  = src_p2[JOY_COIN];
		sys_next.start1 = src_p1[JOY_START];
		sys_next.start2 = src_p2[JOY_START];
	end

	// ==============================
	// Output registers
	// ==============================
	always_ff @(posedge clk_72) begin
		if (reset) begin
			p1  <= '0;
			p2  <= '0;
			sys <= '0;
		end else begin
			p1  <= p1_next;
			p2  <= p2_next;
			sys <= sys_next;
		end
	end

endmodule

//--- src/core_gate.sv
`timescale 1ns/1ps

module core_gate (
	input  logic                 clk_72,
	input  logic                 reset,
	input  logic [63:0]          status,
	input  logic [1:0]           buttons,
	input  logic                 rom_loaded,
	input  logic                 busy,
	input  toaplan_pkg::player_t p1_in,
	input  toaplan_pkg::player_t p2_in,
	input  toaplan_pkg::sys_t    sys_in,
	output logic                 game_reset,
	output toaplan_pkg::player_t p1_out,
	output toaplan_pkg::player_t p2_out,
	output toaplan_pkg::sys_t    sys_out,
	output logic [7:0]           dsw1,
	output logic [7:0]           dsw2,
	output logic [7:0]           dsw3,
	output logic                 led
);
	import toaplan_pkg::*;

	logic reset_cond;

	// Menu reset, board button, missing ROM or a download in progress
	assign reset_cond = status[0] | buttons[1] | ~rom_loaded | busy;

	// ==============================
	// Game reset and input gating
	// ==============================
	always_ff @(posedge clk_72) begin
		if (reset) begin
			game_reset <= 1'b1;
			p1_out     <= '0;
			p2_out     <= '0;
			sys_out    <= '0;
			led        <= 1'b1;
		end else begin
			game_reset <= reset_cond;
			led        <= ~busy;
			// Inputs held at zero for as long as the game is in reset
			if (reset_cond) begin
				p1_out  <= '0;
				p2_out  <= '0;
				sys_out <= '0;
			end else begin
				p1_out  <= p1_in;
				p2_out  <= p2_in;
				sys_out <= sys_in;
			end
		end
	end

	// ==============================
	// DIP switch bytes
	// ==============================
	always_ff @(posedge clk_72) begin
		dsw1 <= status[23:16];
		dsw2 <= status[31:24];
		dsw3 <= status[39:32];
	end

endmodule

//--- src/toaplan_io_top.sv
`timescale 1ns/1ps

module toaplan_io_top #(
	parameter int ROM_INDEX   = 0,
	parameter int ADDR_OFFSET = 2,
	parameter int WORD_ADDR_W = 24
) (
	input  logic                   clk_72,
	input  logic                   reset,
	input  logic                   download,
	input  logic [7:0]             index,
	input  logic                   ioctl_wr,
	input  logic [24:0]            ioctl_addr,
	input  logic [7:0]             ioctl_dout,
	input  logic [63:0]            status,
	input  logic [1:0]             buttons,
	input  logic [31:0]            joystick_0,
	input  logic [31:0]            joystick_1,
	input  logic                   joyswap,
	input  logic                   rotate,
	output logic                   rom_we,
	output logic [WORD_ADDR_W-1:0] rom_addr,
	output toaplan_pkg::rom_word_t rom_data,
	output logic                   game_reset,
	output toaplan_pkg::player_t   p1_out,
	output toaplan_pkg::player_t   p2_out,
	output toaplan_pkg::sys_t      sys_out,
	output logic [7:0]             dsw1,
	output logic [7:0]             dsw2,
	output logic [7:0]             dsw3,
	output logic                   led
);
	import toaplan_pkg::*;

	logic    rom_loaded;
	logic    busy;
	player_t p1_map;
	player_t p2_map;
	sys_t    sys_map;

	// ==============================
	// ROM download path
	// ==============================
	rom_loader #(
		.ROM_INDEX   (ROM_INDEX),
		.ADDR_OFFSET (ADDR_OFFSET),
		.WORD_ADDR_W (WORD_ADDR_W)
	) loader_i (
		.clk_72     (clk_72),
		.reset      (reset),
		.download   (download),
		.index      (index),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.rom_we     (rom_we),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.rom_loaded (rom_loaded),
		.busy       (busy)
	);

	// ==============================
	// Controls and gating
	// ==============================
	control_mapper mapper_i (
		.clk_72     (clk_72),
		.reset      (reset),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joyswap    (joyswap),
		.rotate     (rotate),
		.p1         (p1_map),
		.p2         (p2_map),
		.sys        (sys_map)
	);

	core_gate gate_i (
		.clk_72     (clk_72),
		.reset      (reset),
		.status     (status),
		.buttons    (buttons),
		.rom_loaded (rom_loaded),
		.busy       (busy),
		.p1_in      (p1_map),
		.p2_in      (p2_map),
		.sys_in     (sys_map),
		.game_reset (game_reset),
		.p1_out     (p1_out),
		.p2_out     (p2_out),
		.sys_out    (sys_out),
		.dsw1       (dsw1),
		.dsw2       (dsw2),
		.dsw3       (dsw3),
		.led        (led)
	);

endmodule

//--- verif/toaplan_io_tb.sv
`timescale 1ns/1ps

module toaplan_io_tb;
	import toaplan_pkg::*;

	localparam int N_CTRL  = 11;
	localparam int N_BYTES = 10;
	localparam int TIMEOUT_CYCLES = N_CTRL * 10 + 2 * (2 * N_BYTES + 10) + 20;

	logic        clk_72 = 1'b0;
	logic        reset;
	logic        download;
	logic [7:0]  index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [63:0] status;
	logic [1:0]  buttons;
	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic        joyswap;
	logic        rotate;
	logic        rom_we;
	logic [23:0] rom_addr;
	rom_word_t   rom_data;
	logic        game_reset;
	player_t     p1_out;
	player_t     p2_out;
	sys_t        sys_out;
	logic [7:0]  dsw1;
	logic [7:0]  dsw2;
	logic [7:0]  dsw3;
	logic        led;

	integer      seed = 99134;
	logic [31:0] rnd0;
	logic [31:0] rnd1;
	int          err_player = 0;
	int          err_sys = 0;
	int          err_word = 0;
	int          err_flag = 0;
	int          err_byte = 0;

	// Download image, raw address 0 upward
	logic [7:0] dl_bytes [N_BYTES] = '{8'hde, 8'had, 8'h11, 8'h22, 8'h33,
		8'h44, 8'h5a, 8'ha5, 8'hc3, 8'h3c};

	// Control table
	string       tab_name   [N_CTRL];
	logic [9:0]  tab_joy0   [N_CTRL];
	logic [9:0]  tab_joy1   [N_CTRL];
	logic        tab_swap   [N_CTRL];
	logic        tab_rot    [N_CTRL];
	logic [63:0] tab_status [N_CTRL];
	logic [1:0]  tab_btn    [N_CTRL];
	player_t     tab_p1     [N_CTRL];
	player_t     tab_p2     [N_CTRL];
	sys_t        tab_sys    [N_CTRL];
	logic        tab_reset  [N_CTRL];

	toaplan_io_top dut_i (
		.clk_72     (clk_72),
		.reset      (reset),
		.download   (download),
		.index      (index),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.status     (status),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joyswap    (joyswap),
		.rotate     (rotate),
		.rom_we     (rom_we),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.game_reset (game_reset),
		.p1_out     (p1_out),
		.p2_out     (p2_out),
		.sys_out    (sys_out),
		.dsw1       (dsw1),
		.dsw2       (dsw2),
		.dsw3       (dsw3),
		.led        (led)
	);

	always #20 clk_72 = ~clk_72;

	// ==============================
	// Compare tasks
	// ==============================
	task automatic check_player(input string name, input player_t exp, input player_t act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
			err_player++;
		end
	endtask

	task automatic check_sys(input string name, input sys_t exp, input sys_t act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
			err_sys++;
		end
	endtask

	task automatic check_word(input string name, input logic [23:0] exp_addr,
		input rom_word_t exp_data, input logic [23:0] act_addr, input rom_word_t act_data);
		if (act_addr !== exp_addr || act_data !== exp_data) begin
			$display("MISMATCH %s: expected addr %h data %h, actual addr %h data %h",
				name, exp_addr, exp_data, act_addr, act_data);
			err_word++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
			err_flag++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
			err_byte++;
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================
	task automatic set_entry(input int i, input string name, input logic [9:0] j0,
		input logic [9:0] j1, input logic swap, input logic rot, input logic [63:0] st,
		input logic [1:0] btn, input player_t p1, input player_t p2, input sys_t sy,
		input logic rst);
		tab_name[i]   = name;
		tab_joy0[i]   = j0;
		tab_joy1[i]   = j1;
		tab_swap[i]   = swap;
		tab_rot[i]    = rot;
		tab_status[i] = st;
		tab_btn[i]    = btn;
		tab_p1[i]     = p1;
		tab_p2[i]     = p2;
		tab_sys[i]    = sy;
		tab_reset[i]  = rst;
	endtask

	// Joystick low bits: right, left, down, up, fire x4, coin, start
	task automatic load_table();
		set_entry(0, "plain", 10'h088, 10'h015, 0, 0, 64'h0, 2'b00, 8'h81, 8'h1a, 4'h0, 0);
		set_entry(1, "swap", 10'h088, 10'h015, 1, 0, 64'h0, 2'b00, 8'h1a, 8'h81, 4'h0, 0);
		set_entry(2, "rotate", 10'h088, 10'h015, 0, 1, 64'h0, 2'b00, 8'h84, 8'h19, 4'h0, 0);
		set_entry(3, "swap rot", 10'h088, 10'h015, 1, 1, 64'h0, 2'b00, 8'h19, 8'h84, 4'h0, 0);
		set_entry(4, "coin start", 10'h102, 10'h240, 0, 0, 64'h0, 2'b00, 8'h04, 8'h40, 4'h9, 0);
		set_entry(5, "cs swap", 10'h102, 10'h240, 1, 0, 64'h0, 2'b00, 8'h40, 8'h04, 4'h6, 0);
		set_entry(6, "rot coin", 10'h10f, 10'h204, 0, 1, 64'h0, 2'b00, 8'h0f, 8'h08, 4'h9, 0);
		set_entry(7, "fire sys", 10'h0f0, 10'h300, 0, 0, 64'h0, 2'b00, 8'hf0, 8'h00, 4'ha, 0);
		set_entry(8, "status rst", 10'h088, 10'h015, 0, 0, 64'h0000_0011_2233_0001, 2'b00,
			8'h00, 8'h00, 4'h0, 1);
		set_entry(9, "button rst", 10'h102, 10'h240, 0, 0, 64'h0, 2'b10, 8'h00, 8'h00, 4'h0, 1);
		set_entry(10, "dsw", 10'h088, 10'h015, 0, 0, 64'h0000_00a5_5a3c_0000, 2'b00,
			8'h81, 8'h1a, 4'h0, 0);
	endtask

	// One byte per two cycles, then the end of download
	task automatic run_download(input logic [7:0] idx);
		logic        exp_we;
		logic [23:0] exp_addr;
		rom_word_t   exp_data;
		@(posedge clk_72);
		download <= 1'b1;
		index    <= idx;
		for (int a = 0; a < N_BYTES; a++) begin
			@(posedge clk_72);
			ioctl_wr   <= 1'b1;
			ioctl_addr <= 25'(a);
			ioctl_dout <= dl_bytes[a];
			@(posedge clk_72);
			ioctl_wr <= 1'b0;
			@(negedge clk_72);
			// Word completes on an odd address after the two header bytes
			exp_we = (idx == 8'd0) && (a >= 2) && (((a - 2) % 2) == 1);
			check_flag($sformatf("dl idx %0d byte %0d rom_we", idx, a), exp_we, rom_we);
			if (exp_we) begin
				exp_addr = 24'((a - 2) / 2);
				exp_data = {dl_bytes[a], dl_bytes[a - 1]};
				check_word($sformatf("dl idx %0d byte %0d word", idx, a), exp_addr, exp_data,
					rom_addr, rom_data);
			end
			if (a == 1) begin
				check_flag($sformatf("dl idx %0d led", idx), 1'b0, led);
			end
		end
		@(posedge clk_72);
		download <= 1'b0;
		@(posedge clk_72);
		@(negedge clk_72);
		check_flag($sformatf("dl idx %0d game_reset +1", idx), 1'b1, game_reset);
		@(posedge clk_72);
		@(negedge clk_72);
		check_flag($sformatf("dl idx %0d game_reset +2", idx), 1'b0, game_reset);
	endtask

	initial begin
		reset      <= 1'b1;
		download   <= 1'b0;
		index      <= 8'd0;
		ioctl_wr   <= 1'b0;
		ioctl_addr <= '0;
		ioctl_dout <= '0;
		status     <= '0;
		buttons    <= '0;
		joystick_0 <= '0;
		joystick_1 <= '0;
		joyswap    <= 1'b0;
		rotate     <= 1'b0;
		load_table();

		repeat (3) @(posedge clk_72);
		reset <= 1'b0;
		@(negedge clk_72);
		check_flag("reset game_reset", 1'b1, game_reset);
		check_flag("reset rom_we", 1'b0, rom_we);
		check_flag("reset led", 1'b1, led);
		check_player("reset p1_out", '0, p1_out);
		check_player("reset p2_out", '0, p2_out);
		check_sys("reset sys_out", '0, sys_out);

		run_download(8'd0);
		run_download(8'd5);

		for (int i = 0; i < N_CTRL; i++) begin
			@(posedge clk_72);
			rnd0 = $random(seed);
			rnd1 = $random(seed);
			joystick_0 <= {rnd0[31:10], tab_joy0[i]};
			joystick_1 <= {rnd1[31:10], tab_joy1[i]};
			joyswap    <= tab_swap[i];
			rotate     <= tab_rot[i];
			status     <= tab_status[i];
			buttons    <= tab_btn[i];
			@(posedge clk_72);
			@(negedge clk_72);
			check_flag($sformatf("%s game_reset", tab_name[i]), tab_reset[i], game_reset);
			check_byte($sformatf("%s dsw1", tab_name[i]), tab_status[i][23:16], dsw1);
			check_byte($sformatf("%s dsw2", tab_name[i]), tab_status[i][31:24], dsw2);
			check_byte($sformatf("%s dsw3", tab_name[i]), tab_status[i][39:32], dsw3);
			@(posedge clk_72);
			@(negedge clk_72);
			check_player($sformatf("%s p1_out", tab_name[i]), tab_p1[i], p1_out);
			check_player($sformatf("%s p2_out", tab_name[i]), tab_p2[i], p2_out);
			check_sys($sformatf("%s sys_out", tab_name[i]), tab_sys[i], sys_out);
		end

		$display("Errors: player %0d, sys %0d, word %0d, flag %0d, byte %0d",
			err_player, err_sys, err_word, err_flag, err_byte);
		if (err_player + err_sys + err_word + err_flag + err_byte == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// ==============================
	// Watchdog
	// ==============================
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_72);
		$display("Simulation timed out after %0d cycles before the tests finished",
			TIMEOUT_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- sources.f
src/toaplan_pkg.sv
src/rom_loader.sv
src/control_mapper.sv
src/core_gate.sv
src/toaplan_io_top.sv
verif/toaplan_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f sources.f \
	--top-module toaplan_io_tb -o toaplan_io_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/toaplan_io_sim)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}
